//--- proc_harness_pkg.sv
package proc_harness_pkg;

  // Memory geometry
  localparam int MEM_AW    = 10;            // 1024 words
  localparam int MEM_DEPTH = 1 << MEM_AW;
  localparam int IDX_LSB   = 2;             // Byte address to word index shift

  // Widths with a meaning
  typedef logic [31:0]       word_t;
  typedef logic [31:0]       addr_t;        // Byte address as the core drives it
  typedef logic [3:0]        be_t;          // One bit per byte lane
  typedef logic [MEM_AW-1:0] mem_idx_t;

  // Host command codes
  typedef logic [1:0] host_cmd_t;

  localparam host_cmd_t CMD_NOP   = 2'd0;   // Ack only
  localparam host_cmd_t CMD_WRITE = 2'd1;
  localparam host_cmd_t CMD_READ  = 2'd2;
  localparam host_cmd_t CMD_RUN   = 2'd3;   // Run bit from wdata[0]

  // Core channel bridge
  typedef enum logic [1:0] {
    BR_IDLE,
    BR_WAIT_ACK,   // Strobe held until the RAM acks
    BR_RESP        // Grant and rvalid
  } bridge_state_t;

  // Host command port
  typedef enum logic [1:0] {
    HC_IDLE,
    HC_MEM,
    HC_DONE,
    HC_WAIT_REQ_LOW
  } host_state_t;

endpackage

//--- core_bus_bridge.sv
`timescale 1ns/1ps

module core_bus_bridge (
  input  logic                       clk_core,
  input  logic                       rst_i,
  // Core side, req/gnt/rvalid
  input  logic                       req_i,
  input  logic                       we_i,
  input  proc_harness_pkg::be_t      be_i,
  input  proc_harness_pkg::addr_t    addr_i,
  input  proc_harness_pkg::word_t    wdata_i,
  output logic                       gnt_o,
  output logic                       rvalid_o,
  output proc_harness_pkg::word_t    rdata_o,
  // Memory side, Wishbone style
  output logic                       wb_stb_o,
  output logic                       wb_we_o,
  output proc_harness_pkg::be_t      wb_sel_o,
  output proc_harness_pkg::mem_idx_t wb_idx_o,
  output proc_harness_pkg::word_t    wb_dat_o,
  input  logic                       wb_ack_i,
  input  proc_harness_pkg::word_t    wb_dat_i
);

  proc_harness_pkg::bridge_state_t state_q;
  proc_harness_pkg::bridge_state_t state_d;

  // Request fields, held for the whole memory cycle
  logic                       we_q;
  proc_harness_pkg::be_t      be_q;
  proc_harness_pkg::mem_idx_t idx_q;
  proc_harness_pkg::word_t    wdata_q;
  proc_harness_pkg::word_t    rdata_q;   // Registered RAM read data

  logic accept;
  logic resp_take;

  assign accept    = (state_q == proc_harness_pkg::BR_IDLE) && req_i;
  assign resp_take = (state_q == proc_harness_pkg::BR_WAIT_ACK) && wb_ack_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      proc_harness_pkg::BR_IDLE: begin
        if (req_i) begin
          state_d = proc_harness_pkg::BR_WAIT_ACK;
        end
      end
      proc_harness_pkg::BR_WAIT_ACK: begin
        if (wb_ack_i) begin
          state_d = proc_harness_pkg::BR_RESP;
        end
      end
      proc_harness_pkg::BR_RESP:     state_d = proc_harness_pkg::BR_IDLE; // One-cycle grant
      default:                       state_d = proc_harness_pkg::BR_IDLE;
    endcase
  end

  always_ff @(posedge clk_core) begin
    if (rst_i) begin
      state_q <= proc_harness_pkg::BR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture on leaving IDLE, so a core that changes its fields early
  // cannot disturb the link
  always_ff @(posedge clk_core) begin
    if (accept) begin
      we_q    <= we_i;
      be_q    <= be_i;
      idx_q   <= addr_i[proc_harness_pkg::IDX_LSB +: proc_harness_pkg::MEM_AW];
      wdata_q <= wdata_i;
    end
  end

  always_ff @(posedge clk_core) begin
    if (resp_take) begin
      rdata_q <= wb_dat_i;
    end
  end

  assign wb_stb_o = (state_q == proc_harness_pkg::BR_WAIT_ACK);
  assign wb_we_o  = we_q;
  assign wb_sel_o = be_q;
  assign wb_idx_o = idx_q;
  assign wb_dat_o = wdata_q;

  assign gnt_o    = (state_q == proc_harness_pkg::BR_RESP);
  assign rvalid_o = gnt_o && !we_q;   // Reads only
  assign rdata_o  = rdata_q;

endmodule

//--- harness_ram.sv
`timescale 1ns/1ps

module harness_ram (
  input  logic                       clk_core,
  // Instruction port, read only
  input  logic                       i_stb_i,
  input  proc_harness_pkg::mem_idx_t i_idx_i,
  output logic                       i_ack_o,
  output proc_harness_pkg::word_t    i_dat_o,
  // Data port with byte enables
  input  logic                       d_stb_i,
  input  logic                       d_we_i,
  input  proc_harness_pkg::be_t      d_sel_i,
  input  proc_harness_pkg::mem_idx_t d_idx_i,
  input  proc_harness_pkg::word_t    d_dat_i,
  output logic                       d_ack_o,
  output proc_harness_pkg::word_t    d_dat_o,
  // Host port, whole words
  input  logic                       h_stb_i,
  input  logic                       h_we_i,
  input  proc_harness_pkg::mem_idx_t h_idx_i,
  input  proc_harness_pkg::word_t    h_dat_i,
  output logic                       h_ack_o,
  output proc_harness_pkg::word_t    h_dat_o
);

  proc_harness_pkg::word_t mem [proc_harness_pkg::MEM_DEPTH];

  // A strobe is taken only while that port's ack is low
  logic i_take;
  logic d_take;
  logic h_take;

  assign i_take = i_stb_i && !i_ack_o;
  assign d_take = d_stb_i && !d_ack_o;
  assign h_take = h_stb_i && !h_ack_o;

  // Host writes are refused while the core runs, so the two writers
  // never land in the same cycle
  always_ff @(posedge clk_core) begin
    if (d_take && d_we_i) begin
      for (int b = 0; b < $bits(proc_harness_pkg::be_t); b++) begin
        if (d_sel_i[b]) begin
          mem[d_idx_i][8*b +: 8] <= d_dat_i[8*b +: 8];
        end
      end
    end
    if (h_take && h_we_i) begin
      mem[h_idx_i] <= h_dat_i;
    end
  end

  // Registered reads, valid together with ack
  always_ff @(posedge clk_core) begin
    if (i_take) begin
      i_dat_o <= mem[i_idx_i];
    end
  end

  always_ff @(posedge clk_core) begin
    if (d_take && !d_we_i) begin
      d_dat_o <= mem[d_idx_i];
    end
  end

  always_ff @(posedge clk_core) begin
    if (h_take && !h_we_i) begin
      h_dat_o <= mem[h_idx_i];
    end
  end

  // Acks self-clear within a cycle of the strobes going low in reset
  always_ff @(posedge clk_core) begin
    i_ack_o <= i_take;
    d_ack_o <= d_take;
    h_ack_o <= h_take;
  end

endmodule

//--- host_ctrl.sv
`timescale 1ns/1ps

module host_ctrl (
  input  logic                        clk_core,
  input  logic                        rst_i,
  // Host side, four-phase req/ack
  input  logic                        req_i,
  input  proc_harness_pkg::host_cmd_t cmd_i,
  input  proc_harness_pkg::addr_t     addr_i,
  input  proc_harness_pkg::word_t     wdata_i,
  output logic                        ack_o,
  output proc_harness_pkg::word_t     rdata_o,
  output logic                        refused_o,
  // RAM host port
  output logic                        mem_stb_o,
  output logic                        mem_we_o,
  output proc_harness_pkg::mem_idx_t  mem_idx_o,
  output proc_harness_pkg::word_t     mem_dat_o,
  input  logic                        mem_ack_i,
  input  proc_harness_pkg::word_t     mem_dat_i,
  // Core run control
  output logic                        run_o
);

  proc_harness_pkg::host_state_t state_q;

  logic                       run_q;
  logic                       refused_q;
  logic                       we_q;
  proc_harness_pkg::mem_idx_t idx_q;
  proc_harness_pkg::word_t    wdata_q;
  proc_harness_pkg::word_t    rdata_q;

  logic is_mem_cmd;

  assign is_mem_cmd = (cmd_i == proc_harness_pkg::CMD_WRITE) ||
                      (cmd_i == proc_harness_pkg::CMD_READ);

  always_ff @(posedge clk_core) begin
    if (rst_i) begin
      state_q   <= proc_harness_pkg::HC_IDLE;
      run_q     <= 1'b0;      // Core held in reset
      refused_q <= 1'b0;
    end else begin
      case (state_q)
        proc_harness_pkg::HC_IDLE: begin
          if (req_i) begin
            refused_q <= is_mem_cmd && run_q;
            if (is_mem_cmd && !run_q) begin
              state_q <= proc_harness_pkg::HC_MEM;
            end else begin
              state_q <= proc_harness_pkg::HC_DONE;
            end
            if (cmd_i == proc_harness_pkg::CMD_RUN) begin
              run_q <= wdata_i[0];
            end
          end
        end
        proc_harness_pkg::HC_MEM: begin
          if (mem_ack_i) begin
            state_q <= proc_harness_pkg::HC_DONE;
          end
        end
        proc_harness_pkg::HC_DONE: state_q <= proc_harness_pkg::HC_WAIT_REQ_LOW;
        proc_harness_pkg::HC_WAIT_REQ_LOW: begin
          if (!req_i) begin
            state_q <= proc_harness_pkg::HC_IDLE;  // Ack drops here
          end
        end
        default: state_q <= proc_harness_pkg::HC_IDLE;
      endcase
    end
  end

  // Command fields and response word
  always_ff @(posedge clk_core) begin
    if (state_q == proc_harness_pkg::HC_IDLE && req_i) begin
      we_q    <= (cmd_i == proc_harness_pkg::CMD_WRITE);
      idx_q   <= addr_i[proc_harness_pkg::IDX_LSB +: proc_harness_pkg::MEM_AW];
      wdata_q <= wdata_i;
      if (cmd_i == proc_harness_pkg::CMD_RUN) begin
        rdata_q <= {31'b0, wdata_i[0]};   // New run value
      end else begin
        rdata_q <= '0;                    // Also the refused response
      end
    end else if (state_q == proc_harness_pkg::HC_MEM && mem_ack_i && !we_q) begin
      rdata_q <= mem_dat_i;
    end
  end

  assign mem_stb_o = (state_q == proc_harness_pkg::HC_MEM);
  assign mem_we_o  = we_q;
  assign mem_idx_o = idx_q;
  assign mem_dat_o = wdata_q;

  assign ack_o     = (state_q == proc_harness_pkg::HC_DONE) ||
                     (state_q == proc_harness_pkg::HC_WAIT_REQ_LOW);
  assign rdata_o   = rdata_q;
  assign refused_o = refused_q;
  assign run_o     = run_q;

endmodule

//--- proc_harness_top.sv
`timescale 1ns/1ps

module proc_harness_top (
  input  logic                        clk_core,
  input  logic                        rst_i,
  // Core instruction channel
  input  logic                        instr_req_i,
  input  proc_harness_pkg::addr_t     instr_addr_i,
  output logic                        instr_gnt_o,
  output logic                        instr_rvalid_o,
  output proc_harness_pkg::word_t     instr_rdata_o,
  // Core data channel
  input  logic                        data_req_i,
  input  logic                        data_we_i,
  input  proc_harness_pkg::be_t       data_be_i,
  input  proc_harness_pkg::addr_t     data_addr_i,
  input  proc_harness_pkg::word_t     data_wdata_i,
  output logic                        data_gnt_o,
  output logic                        data_rvalid_o,
  output proc_harness_pkg::word_t     data_rdata_o,
  // Host port
  input  logic                        host_req_i,
  input  proc_harness_pkg::host_cmd_t host_cmd_i,
  input  proc_harness_pkg::addr_t     host_addr_i,
  input  proc_harness_pkg::word_t     host_wdata_i,
  output logic                        host_ack_o,
  output proc_harness_pkg::word_t     host_rdata_o,
  output logic                        host_refused_o,
  // Reset for the external core
  output logic                        core_rst_o
);

  // Instruction link
  logic                       i_stb;
  logic                       i_ack;
  proc_harness_pkg::mem_idx_t i_idx;
  proc_harness_pkg::word_t    i_dat;

  // Data link
  logic                       d_stb;
  logic                       d_we;
  logic                       d_ack;
  proc_harness_pkg::be_t      d_sel;
  proc_harness_pkg::mem_idx_t d_idx;
  proc_harness_pkg::word_t    d_dat_w;
  proc_harness_pkg::word_t    d_dat_r;

  // Host link
  logic                       h_stb;
  logic                       h_we;
  logic                       h_ack;
  proc_harness_pkg::mem_idx_t h_idx;
  proc_harness_pkg::word_t    h_dat_w;
  proc_harness_pkg::word_t    h_dat_r;

  logic run;

  core_bus_bridge u_instr_bridge (
    .clk_core (clk_core),
    .rst_i    (rst_i),
    .req_i    (instr_req_i),
    .we_i     (1'b0),       // Read only
    .be_i     (4'h0),
    .addr_i   (instr_addr_i),
    .wdata_i  (32'h0),
    .gnt_o    (instr_gnt_o),
    .rvalid_o (instr_rvalid_o),
    .rdata_o  (instr_rdata_o),
    .wb_stb_o (i_stb),
    .wb_we_o  (),
    .wb_sel_o (),
    .wb_idx_o (i_idx),
    .wb_dat_o (),
    .wb_ack_i (i_ack),
    .wb_dat_i (i_dat)
  );

  core_bus_bridge u_data_bridge (
    .clk_core (clk_core),
    .rst_i    (rst_i),
    .req_i    (data_req_i),
    .we_i     (data_we_i),
    .be_i     (data_be_i),
    .addr_i   (data_addr_i),
    .wdata_i  (data_wdata_i),
    .gnt_o    (data_gnt_o),
    .rvalid_o (data_rvalid_o),
    .rdata_o  (data_rdata_o),
    .wb_stb_o (d_stb),
    .wb_we_o  (d_we),
    .wb_sel_o (d_sel),
    .wb_idx_o (d_idx),
    .wb_dat_o (d_dat_w),
    .wb_ack_i (d_ack),
    .wb_dat_i (d_dat_r)
  );

  harness_ram u_ram (
    .clk_core (clk_core),
    .i_stb_i  (i_stb),
    .i_idx_i  (i_idx),
    .i_ack_o  (i_ack),
    .i_dat_o  (i_dat),
    .d_stb_i  (d_stb),
    .d_we_i   (d_we),
    .d_sel_i  (d_sel),
    .d_idx_i  (d_idx),
    .d_dat_i  (d_dat_w),
    .d_ack_o  (d_ack),
    .d_dat_o  (d_dat_r),
    .h_stb_i  (h_stb),
    .h_we_i   (h_we),
    .h_idx_i  (h_idx),
    .h_dat_i  (h_dat_w),
    .h_ack_o  (h_ack),
    .h_dat_o  (h_dat_r)
  );

  host_ctrl u_host_ctrl (
    .clk_core  (clk_core),
    .rst_i     (rst_i),
    .req_i     (host_req_i),
    .cmd_i     (host_cmd_i),
    .addr_i    (host_addr_i),
    .wdata_i   (host_wdata_i),
    .ack_o     (host_ack_o),
    .rdata_o   (host_rdata_o),
    .refused_o (host_refused_o),
    .mem_stb_o (h_stb),
    .mem_we_o  (h_we),
    .mem_idx_o (h_idx),
    .mem_dat_o (h_dat_w),
    .mem_ack_i (h_ack),
    .mem_dat_i (h_dat_r),
    .run_o     (run)
  );

  assign core_rst_o = !run;   // Core held in reset until the host sets run

endmodule

//--- tb_proc_harness.sv
`timescale 1ns/1ps

module tb_proc_harness;

  localparam int CLK_HALF = 50;
  localparam int DRV_DLY  = 10;   // Inputs change this long after the rising edge
  localparam int GNT_LAT  = 3;
  localparam int WAIT_MAX = 40;   // Cycles before any wait gives up
  localparam int WIN      = 64;   // Words the test touches
  localparam int N_LOAD   = 20;
  localparam int N_MIX    = 50;

  logic                        clk_core;
  logic                        rst_i;
  logic                        instr_req_i;
  proc_harness_pkg::addr_t     instr_addr_i;
  logic                        instr_gnt_o;
  logic                        instr_rvalid_o;
  proc_harness_pkg::word_t     instr_rdata_o;
  logic                        data_req_i;
  logic                        data_we_i;
  proc_harness_pkg::be_t       data_be_i;
  proc_harness_pkg::addr_t     data_addr_i;
  proc_harness_pkg::word_t     data_wdata_i;
  logic                        data_gnt_o;
  logic                        data_rvalid_o;
  proc_harness_pkg::word_t     data_rdata_o;
  logic                        host_req_i;
  proc_harness_pkg::host_cmd_t host_cmd_i;
  proc_harness_pkg::addr_t     host_addr_i;
  proc_harness_pkg::word_t     host_wdata_i;
  logic                        host_ack_o;
  proc_harness_pkg::word_t     host_rdata_o;
  logic                        host_refused_o;
  logic                        core_rst_o;

  proc_harness_pkg::word_t model [proc_harness_pkg::MEM_DEPTH];   // Expected RAM contents
  logic run_exp;   // Run bit as the host last set it
  integer seed;
  int val_errs   = 0;
  int prot_errs  = 0;
  int tmo_errs   = 0;
  int instr_reqs = 0;
  int instr_gnts = 0;
  int data_reqs  = 0;
  int data_gnts  = 0;

  proc_harness_top DUT (.*);

  initial begin
    clk_core = 1'b0;
    forever #CLK_HALF clk_core = ~clk_core;
  end

  always @(posedge clk_core) begin
    if (!rst_i && instr_gnt_o) instr_gnts++;
    if (!rst_i && data_gnt_o) data_gnts++;
  end

  task automatic flag_protocol(input string what);
    prot_errs++;
    $display("protocol violation: %s", what);
  endtask

  a_instr_gnt: assert property (@(posedge clk_core) disable iff (rst_i)
    instr_gnt_o |=> !instr_gnt_o) else flag_protocol("instr_gnt_o longer than one cycle");
  a_data_gnt: assert property (@(posedge clk_core) disable iff (rst_i)
    data_gnt_o |=> !data_gnt_o) else flag_protocol("data_gnt_o longer than one cycle");
  a_no_wr_rvalid: assert property (@(posedge clk_core) disable iff (rst_i)
    data_gnt_o && data_we_i |-> !data_rvalid_o) else flag_protocol("data_rvalid_o on a write");
  a_ack_fall: assert property (@(posedge clk_core) disable iff (rst_i)
    $fell(host_ack_o) |-> !$past(host_req_i)) else flag_protocol("host_ack_o fell before req");
  a_core_rst: assert property (@(posedge clk_core) disable iff (rst_i)
    !run_exp && !host_req_i |-> core_rst_o) else flag_protocol("core_rst_o low while run is 0");

  // Fill depends on every index bit
  function automatic proc_harness_pkg::word_t fill_word(proc_harness_pkg::mem_idx_t idx);
    return {6'h2b, idx, 6'h15, idx};
  endfunction

  // Upper bits and byte offset are junk, only bits 11:2 select the word
  function automatic proc_harness_pkg::addr_t word_addr(proc_harness_pkg::mem_idx_t idx);
    proc_harness_pkg::word_t junk;
    junk = $random(seed);
    return {junk[31:12], idx, junk[1:0]};
  endfunction

  function automatic proc_harness_pkg::mem_idx_t idx_of(proc_harness_pkg::addr_t a);
    return a[11:2];
  endfunction

  function automatic proc_harness_pkg::mem_idx_t pick_idx(int base, int span);
    proc_harness_pkg::word_t r;
    r = $random(seed);
    return proc_harness_pkg::mem_idx_t'(base + int'(r[15:0]) % span);
  endfunction

  function automatic proc_harness_pkg::word_t merge_bytes(proc_harness_pkg::word_t old_w,
      proc_harness_pkg::word_t new_w, proc_harness_pkg::be_t be);
    proc_harness_pkg::word_t mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (new_w & mask) | (old_w & ~mask);
  endfunction

  task automatic check_word(input string name, input proc_harness_pkg::word_t exp,
                            input proc_harness_pkg::word_t got);
    assert (got === exp) else begin
      val_errs++;
      $display("error %s expected %h got %h", name, exp, got);
    end
  endtask

  task automatic report_timeout(input string what);
    tmo_errs++;
    $display("timeout while waiting for %s", what);
  endtask

  task automatic next_cycle;
    @(posedge clk_core);
    #DRV_DLY;
  endtask

  task automatic host_xfer(input proc_harness_pkg::host_cmd_t cmd,
                           input proc_harness_pkg::addr_t addr,
                           input proc_harness_pkg::word_t wdata,
                           output proc_harness_pkg::word_t rdata, output logic refused);
    int n;
    proc_harness_pkg::word_t r;
    host_req_i   = 1'b1;
    host_cmd_i   = cmd;
    host_addr_i  = addr;
    host_wdata_i = wdata;
    n = 0;
    do begin
      next_cycle();
      n++;
    end while (!host_ack_o && n < WAIT_MAX);
    if (!host_ack_o) report_timeout("host_ack_o to rise");
    rdata   = host_rdata_o;
    refused = host_refused_o;
    if (host_ack_o && cmd == proc_harness_pkg::CMD_RUN) begin
      run_exp = wdata[0];
    end
    r = $random(seed);
    repeat (r[1:0]) next_cycle();   // Host may keep req up a while after ack
    host_req_i = 1'b0;
    n = 0;
    do begin
      next_cycle();
      n++;
    end while (host_ack_o && n < WAIT_MAX);
    if (host_ack_o) report_timeout("host_ack_o to fall");
  endtask

  task automatic core_instr(input proc_harness_pkg::addr_t addr,
                            output proc_harness_pkg::word_t rdata);
    int n;
    instr_req_i  = 1'b1;
    instr_addr_i = addr;
    instr_reqs++;
    n = 0;
    do begin
      next_cycle();
      n++;
    end while (!instr_gnt_o && n < WAIT_MAX);
    if (!instr_gnt_o) begin
      report_timeout("instr_gnt_o");
    end else begin
      check_word("instr_gnt_o latency", proc_harness_pkg::word_t'(GNT_LAT),
                 proc_harness_pkg::word_t'(n));
      check_word("instr_rvalid_o", 32'd1, proc_harness_pkg::word_t'(instr_rvalid_o));
    end
    rdata = instr_rdata_o;
    next_cycle();   // Edge where the core takes the grant
    instr_req_i = 1'b0;
  endtask

  task automatic core_data(input logic we, input proc_harness_pkg::be_t be,
                           input proc_harness_pkg::addr_t addr,
                           input proc_harness_pkg::word_t wdata,
                           output proc_harness_pkg::word_t rdata);
    int n;
    data_req_i   = 1'b1;
    data_we_i    = we;
    data_be_i    = be;
    data_addr_i  = addr;
    data_wdata_i = wdata;
    data_reqs++;
    n = 0;
    do begin
      next_cycle();
      n++;
    end while (!data_gnt_o && n < WAIT_MAX);
    if (!data_gnt_o) begin
      report_timeout("data_gnt_o");
    end else begin
      check_word("data_gnt_o latency", proc_harness_pkg::word_t'(GNT_LAT),
                 proc_harness_pkg::word_t'(n));
      check_word("data_rvalid_o", proc_harness_pkg::word_t'(!we),
                 proc_harness_pkg::word_t'(data_rvalid_o));
    end
    rdata = data_rdata_o;
    next_cycle();
    data_req_i = 1'b0;
  endtask

  initial begin
    proc_harness_pkg::word_t    rd;
    proc_harness_pkg::word_t    wd;
    proc_harness_pkg::mem_idx_t idx;
    logic                       refused;
    proc_harness_pkg::addr_t    load_addr [N_LOAD];
    proc_harness_pkg::addr_t    mix_iaddr [N_MIX];
    proc_harness_pkg::addr_t    mix_daddr [N_MIX];
    proc_harness_pkg::word_t    mix_wd [N_MIX];
    proc_harness_pkg::word_t    mix_ctl [N_MIX];   // Bit 0 write, bits 7:4 byte enables
    seed = 32'ha4a914a7;
    run_exp = 1'b0;
    rst_i = 1'b1;
    instr_req_i = 1'b0;
    instr_addr_i = '0;
    data_req_i = 1'b0;
    data_we_i = 1'b0;
    data_be_i = '0;
    data_addr_i = '0;
    data_wdata_i = '0;
    host_req_i = 1'b0;
    host_cmd_i = proc_harness_pkg::CMD_NOP;
    host_addr_i = '0;
    host_wdata_i = '0;
    repeat (4) @(posedge clk_core);
    #DRV_DLY;
    rst_i = 1'b0;
    check_word("core_rst_o", 32'd1, proc_harness_pkg::word_t'(core_rst_o));

    for (int i = 0; i < WIN; i++) begin
      idx = proc_harness_pkg::mem_idx_t'(i);
      model[idx] = fill_word(idx);
      host_xfer(proc_harness_pkg::CMD_WRITE, word_addr(idx), model[idx], rd, refused);
    end
    for (int i = 0; i < N_LOAD; i++) begin
      load_addr[i] = word_addr(pick_idx(0, WIN));
      wd = $random(seed);
      model[idx_of(load_addr[i])] = wd;
      host_xfer(proc_harness_pkg::CMD_WRITE, load_addr[i], wd, rd, refused);
      check_word("host_refused_o", 32'd0, proc_harness_pkg::word_t'(refused));
    end
    for (int i = 0; i < N_LOAD; i++) begin
      host_xfer(proc_harness_pkg::CMD_READ, load_addr[i], '0, rd, refused);
      check_word("host_rdata_o", model[idx_of(load_addr[i])], rd);
      check_word("host_refused_o", 32'd0, proc_harness_pkg::word_t'(refused));
    end
    host_xfer(proc_harness_pkg::CMD_NOP, '0, 32'hffff_ffff, rd, refused);
    check_word("host_rdata_o", 32'd0, rd);

    // Start the core, then memory commands must bounce
    host_xfer(proc_harness_pkg::CMD_RUN, '0, 32'd1, rd, refused);
    check_word("host_rdata_o", 32'd1, rd);
    check_word("core_rst_o", 32'd0, proc_harness_pkg::word_t'(core_rst_o));
    host_xfer(proc_harness_pkg::CMD_READ, word_addr(pick_idx(0, WIN)), '0, rd, refused);
    check_word("host_refused_o", 32'd1, proc_harness_pkg::word_t'(refused));
    check_word("host_rdata_o", 32'd0, rd);
    idx = pick_idx(0, WIN);
    host_xfer(proc_harness_pkg::CMD_WRITE, word_addr(idx), ~model[idx], rd, refused);
    check_word("host_refused_o", 32'd1, proc_harness_pkg::word_t'(refused));
    check_word("host_rdata_o", 32'd0, rd);
    core_data(1'b0, 4'hf, word_addr(idx), '0, rd);
    check_word("data_rdata_o", model[idx], rd);

    for (int i = 0; i < 16; i++) begin
      idx = pick_idx(0, WIN);
      core_instr(word_addr(idx), rd);
      check_word("instr_rdata_o", model[idx], rd);
    end

    for (int i = 0; i < 16; i++) begin
      idx = pick_idx(0, WIN);
      wd = $random(seed);
      mix_ctl[0] = $random(seed);
      core_data(1'b1, proc_harness_pkg::be_t'(mix_ctl[0]), word_addr(idx), wd, rd);
      model[idx] = merge_bytes(model[idx], wd, proc_harness_pkg::be_t'(mix_ctl[0]));
      core_data(1'b0, 4'hf, word_addr(idx), '0, rd);
      check_word("data_rdata_o", model[idx], rd);
    end

    // Fetches stay in the lower half, data in the upper half
    for (int i = 0; i < N_MIX; i++) begin
      mix_iaddr[i] = word_addr(pick_idx(0, WIN / 2));
      mix_daddr[i] = word_addr(pick_idx(WIN / 2, WIN / 2));
      mix_wd[i] = $random(seed);
      mix_ctl[i] = $random(seed);
    end
    fork
      begin
        proc_harness_pkg::word_t ird;
        for (int i = 0; i < N_MIX; i++) begin
          core_instr(mix_iaddr[i], ird);
          check_word("instr_rdata_o", model[idx_of(mix_iaddr[i])], ird);
        end
      end
      begin
        proc_harness_pkg::word_t    drd;
        proc_harness_pkg::mem_idx_t di;
        for (int i = 0; i < N_MIX; i++) begin
          di = idx_of(mix_daddr[i]);
          core_data(mix_ctl[i][0], mix_ctl[i][7:4], mix_daddr[i], mix_wd[i], drd);
          if (mix_ctl[i][0]) begin
            model[di] = merge_bytes(model[di], mix_wd[i], mix_ctl[i][7:4]);
          end else begin
            check_word("data_rdata_o", model[di], drd);
          end
        end
      end
    join
    check_word("instr grant count", proc_harness_pkg::word_t'(instr_reqs),
               proc_harness_pkg::word_t'(instr_gnts));
    check_word("data grant count", proc_harness_pkg::word_t'(data_reqs),
               proc_harness_pkg::word_t'(data_gnts));

    host_xfer(proc_harness_pkg::CMD_RUN, '0, 32'd0, rd, refused);
    check_word("host_rdata_o", 32'd0, rd);
    check_word("core_rst_o", 32'd1, proc_harness_pkg::word_t'(core_rst_o));
    for (int i = 0; i < WIN; i++) begin
      idx = proc_harness_pkg::mem_idx_t'(i);
      host_xfer(proc_harness_pkg::CMD_READ, word_addr(idx), '0, rd, refused);
      check_word("host_rdata_o", model[idx], rd);
    end

    next_cycle();
    $display("checks done: %0d value errors, %0d protocol errors, %0d timeouts",
             val_errs, prot_errs, tmo_errs);
    if (val_errs + prot_errs + tmo_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- proc_harness.f
proc_harness_pkg.sv
core_bus_bridge.sv
harness_ram.sv
host_ctrl.sv
proc_harness_top.sv
tb_proc_harness.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the harness testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_proc_harness -f proc_harness.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
